// File: hdl/issue_pkg.sv
/*
 * Shared types for the decode-issue stage: width typedefs,
 * micro-op codes and the per-pipe op-mask constants
 */

package issue_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Data and pc word
  typedef logic [31:0] word_t;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // Micro-op code
  typedef logic [2:0] uop_t;

  // One bit per micro-op, indexed by the uop code
  typedef logic [7:0] op_mask_t;

  // ----------------------------------------------------------
  // Micro-op codes
  // ----------------------------------------------------------

  localparam uop_t uop_add  = 3'd0;
  localparam uop_t uop_addi = 3'd1;
  localparam uop_t uop_mul  = 3'd2;
  localparam uop_t uop_lw   = 3'd3;
  localparam uop_t uop_jal  = 3'd4;
  localparam uop_t uop_jalr = 3'd5;

  // ----------------------------------------------------------
  // Pipe capability masks
  // ----------------------------------------------------------

  // Every micro-op the stage can produce
  localparam op_mask_t op_mask_all = (op_mask_t'(1) << uop_add)
                                   | (op_mask_t'(1) << uop_addi)
                                   | (op_mask_t'(1) << uop_mul)
                                   | (op_mask_t'(1) << uop_lw)
                                   | (op_mask_t'(1) << uop_jal)
                                   | (op_mask_t'(1) << uop_jalr);

  // Simple integer pipe, jumps included
  localparam op_mask_t op_mask_alu = (op_mask_t'(1) << uop_add)
                                   | (op_mask_t'(1) << uop_addi)
                                   | (op_mask_t'(1) << uop_jal)
                                   | (op_mask_t'(1) << uop_jalr);

endpackage

// File: hdl/inst_decoder.sv
/*
 * Combinational RV32 decoder for ADD, ADDI, MUL, LW, JAL and JALR
 */

module inst_decoder (
  input  issue_pkg::word_t     inst,
  input  issue_pkg::word_t     pc,
  output issue_pkg::uop_t      uop,
  output issue_pkg::reg_addr_t rs1,
  output issue_pkg::reg_addr_t rs2,
  output issue_pkg::reg_addr_t rd,
  output logic                 use_rs1,
  output logic                 use_rs2,
  output issue_pkg::word_t     imm,
  output logic                 pc_as_op1
);

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  issue_pkg::word_t imm_i;
  issue_pkg::word_t imm_j;
  logic             aligned;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // All kept formats put the register fields in the same place
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // No compressed instructions, so fetch must be word aligned
  assign aligned = (pc[1:0] == 2'b00);

  // Illegal encodings and misaligned fetches fall through as an
  // ADDI of pc plus zero, reading no registers
  always_comb begin
    uop       = issue_pkg::uop_addi;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    imm       = '0;
    pc_as_op1 = 1'b1;
    if (aligned) begin
      case (opcode)
        opc_op: begin
          if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
            uop = issue_pkg::uop_add;
          end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
            uop = issue_pkg::uop_mul;
          end
          if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0000001)) begin
            use_rs1   = 1'b1;
            use_rs2   = 1'b1;
            pc_as_op1 = 1'b0;
          end
        end
        opc_op_imm, opc_load, opc_jalr: begin
          if ((opcode == opc_op_imm && funct3 == 3'b000) ||
              (opcode == opc_load && funct3 == 3'b010) ||
              (opcode == opc_jalr && funct3 == 3'b000)) begin
            uop       = (opcode == opc_load) ? issue_pkg::uop_lw :
                        (opcode == opc_jalr) ? issue_pkg::uop_jalr : issue_pkg::uop_addi;
            use_rs1   = 1'b1;
            imm       = imm_i;
            pc_as_op1 = 1'b0;
          end
        end
        opc_jal: begin
          uop = issue_pkg::uop_jal;
          imm = imm_j;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/reg_file.sv
/*
 * 32-entry register file, one write port fed by completions,
 * two read ports with write-to-read bypass
 */

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wen,
  input  issue_pkg::reg_addr_t waddr,
  input  issue_pkg::word_t     wdata,
  input  issue_pkg::reg_addr_t raddr0,
  input  issue_pkg::reg_addr_t raddr1,
  output issue_pkg::word_t     rdata0,
  output issue_pkg::word_t     rdata1
);

  issue_pkg::word_t regs [32];

  // Entry 0 is never written and stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle write shows up on the read side
  always_comb begin
    rdata0 = regs[raddr0];
    if (raddr0 == '0) begin
      rdata0 = '0;
    end else if (wen && waddr == raddr0) begin
      rdata0 = wdata;
    end
    rdata1 = regs[raddr1];
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else if (wen && waddr == raddr1) begin
      rdata1 = wdata;
    end
  end

endmodule

// File: hdl/reg_scoreboard.sv
/*
 * Pending-write scoreboard: one pending bit and the sequence
 * number of its writer per register, with RAW/WAW hazard check
 */

module reg_scoreboard #(
  parameter int seq_bits = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 set_val,
  input  issue_pkg::reg_addr_t set_addr,
  input  logic [seq_bits-1:0]  set_seq,
  input  logic                 clr_val,
  input  issue_pkg::reg_addr_t clr_addr,
  input  logic [seq_bits-1:0]  clr_seq,
  input  issue_pkg::reg_addr_t chk_rs1,
  input  issue_pkg::reg_addr_t chk_rs2,
  input  issue_pkg::reg_addr_t chk_rd,
  input  logic                 use_rs1,
  input  logic                 use_rs2,
  output logic                 busy
);

  logic [31:0]         pending;
  logic [seq_bits-1:0] writer [32];
  logic                clr_hit;
  logic [31:0]         live;

  // Stale completions carry an older seq and leave the bit alone
  assign clr_hit = clr_val && pending[clr_addr] && (writer[clr_addr] == clr_seq);

  // Pending view with this cycle's matching clear already applied
  always_comb begin
    live = pending;
    if (clr_hit) begin
      live[clr_addr] = 1'b0;
    end
    live[0] = 1'b0;
  end

  assign busy = (use_rs1 && live[chk_rs1]) || (use_rs2 && live[chk_rs2]) || live[chk_rd];

  // A new writer marked in the same cycle overrides the clear
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (clr_hit) begin
        pending[clr_addr] <= 1'b0;
      end
      if (set_val && set_addr != '0) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (set_val) begin
      writer[set_addr] <= set_seq;
    end
  end

endmodule

// File: hdl/issue_ctrl.sv
/*
 * Decode register, hazard stall, pipe steering and the
 * fetch and execute valid/ready handshakes
 */

module issue_ctrl #(
  parameter int                                  seq_bits  = 5,
  parameter int                                  num_pipes = 3,
  parameter issue_pkg::op_mask_t [num_pipes-1:0] pipe_ops  =
    {num_pipes{issue_pkg::op_mask_all}}
) (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch side
  input  logic                 f_val,
  output logic                 f_rdy,
  input  issue_pkg::word_t     f_inst,
  input  issue_pkg::word_t     f_pc,
  input  logic [seq_bits-1:0]  f_seq,
  // Execute side
  input  logic [num_pipes-1:0] x_rdy,
  output logic [num_pipes-1:0] x_val,
  output issue_pkg::word_t     x_pc,
  output logic [seq_bits-1:0]  x_seq,
  output issue_pkg::word_t     x_op1,
  output issue_pkg::word_t     x_op2,
  output issue_pkg::reg_addr_t x_waddr,
  output issue_pkg::uop_t      x_uop,
  // Decoder, register file and scoreboard
  input  issue_pkg::uop_t      dec_uop,
  input  issue_pkg::word_t     dec_imm,
  input  logic                 dec_pc_as_op1,
  input  issue_pkg::word_t     rdata0,
  input  issue_pkg::word_t     rdata1,
  input  logic                 busy,
  output issue_pkg::word_t     d_inst,
  output issue_pkg::word_t     d_pc,
  output logic                 set_val,
  output issue_pkg::reg_addr_t set_addr,
  output logic [seq_bits-1:0]  set_seq
);

  logic                 d_val;
  logic [seq_bits-1:0]  d_seq;
  logic [num_pipes-1:0] capable;
  logic [num_pipes-1:0] cand;
  logic [num_pipes-1:0] pick;
  logic                 issue;

  // ----------------------------------------------------------
  // Decode register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (f_val && f_rdy) begin
      d_val <= 1'b1;
    end else if (issue) begin
      d_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_val && f_rdy) begin
      d_inst <= f_inst;
      d_pc   <= f_pc;
      d_seq  <= f_seq;
    end
  end

  // Refill in the same cycle the held instruction leaves
  assign f_rdy = !d_val || issue;

  // ----------------------------------------------------------
  // Steering
  // ----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_pipes; i++) begin
      capable[i] = pipe_ops[i][dec_uop];
    end
  end

  assign cand = capable & x_rdy;

  // Lowest set bit wins
  assign pick  = cand & (~cand + 1'b1);
  assign x_val = (d_val && !busy) ? pick : '0;
  assign issue = |x_val;

  // ----------------------------------------------------------
  // Payload and scoreboard update
  // ----------------------------------------------------------

  assign x_pc    = d_pc;
  assign x_seq   = d_seq;
  assign x_uop   = dec_uop;
  assign x_waddr = d_inst[11:7];

  assign x_op1 = dec_pc_as_op1 ? d_pc : rdata0;
  // Only the register-register ops take rs2
  assign x_op2 = (dec_uop == issue_pkg::uop_add || dec_uop == issue_pkg::uop_mul) ?
                 rdata1 : dec_imm;

  assign set_val  = issue;
  assign set_addr = d_inst[11:7];
  assign set_seq  = d_seq;

endmodule

// File: hdl/decode_issue_top.sv
/*
 * Decode-issue stage top level: decoder, register file,
 * scoreboard and issue control
 */

module decode_issue_top #(
  parameter int                                  seq_bits  = 5,
  parameter int                                  num_pipes = 3,
  parameter issue_pkg::op_mask_t [num_pipes-1:0] pipe_ops  =
    {num_pipes{issue_pkg::op_mask_all}}
) (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch
  input  logic                 f_val,
  output logic                 f_rdy,
  input  issue_pkg::word_t     f_inst,
  input  issue_pkg::word_t     f_pc,
  input  logic [seq_bits-1:0]  f_seq,
  // Execute pipes
  output logic [num_pipes-1:0] x_val,
  input  logic [num_pipes-1:0] x_rdy,
  output issue_pkg::word_t     x_pc,
  output logic [seq_bits-1:0]  x_seq,
  output issue_pkg::word_t     x_op1,
  output issue_pkg::word_t     x_op2,
  output issue_pkg::reg_addr_t x_waddr,
  output issue_pkg::uop_t      x_uop,
  // Completion notification
  input  logic                 c_val,
  input  logic [seq_bits-1:0]  c_seq,
  input  issue_pkg::reg_addr_t c_waddr,
  input  issue_pkg::word_t     c_wdata,
  input  logic                 c_wen
);

  issue_pkg::word_t     d_inst;
  issue_pkg::word_t     d_pc;
  issue_pkg::uop_t      dec_uop;
  issue_pkg::reg_addr_t dec_rs1;
  issue_pkg::reg_addr_t dec_rs2;
  issue_pkg::reg_addr_t dec_rd;
  logic                 dec_use_rs1;
  logic                 dec_use_rs2;
  issue_pkg::word_t     dec_imm;
  logic                 dec_pc_as_op1;
  issue_pkg::word_t     rdata0;
  issue_pkg::word_t     rdata1;
  logic                 busy;
  logic                 set_val;
  issue_pkg::reg_addr_t set_addr;
  logic [seq_bits-1:0]  set_seq;

  inst_decoder u_inst_decoder (
    .inst      (d_inst),
    .pc        (d_pc),
    .uop       (dec_uop),
    .rs1       (dec_rs1),
    .rs2       (dec_rs2),
    .rd        (dec_rd),
    .use_rs1   (dec_use_rs1),
    .use_rs2   (dec_use_rs2),
    .imm       (dec_imm),
    .pc_as_op1 (dec_pc_as_op1)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .wen    (c_val && c_wen),
    .waddr  (c_waddr),
    .wdata  (c_wdata),
    .raddr0 (dec_rs1),
    .raddr1 (dec_rs2),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  reg_scoreboard #(
    .seq_bits (seq_bits)
  ) u_reg_scoreboard (
    .clk      (clk),
    .rst      (rst),
    .set_val  (set_val),
    .set_addr (set_addr),
    .set_seq  (set_seq),
    .clr_val  (c_val),
    .clr_addr (c_waddr),
    .clr_seq  (c_seq),
    .chk_rs1  (dec_rs1),
    .chk_rs2  (dec_rs2),
    .chk_rd   (dec_rd),
    .use_rs1  (dec_use_rs1),
    .use_rs2  (dec_use_rs2),
    .busy     (busy)
  );

  issue_ctrl #(
    .seq_bits  (seq_bits),
    .num_pipes (num_pipes),
    .pipe_ops  (pipe_ops)
  ) u_issue_ctrl (
    .clk           (clk),
    .rst           (rst),
    .f_val         (f_val),
    .f_rdy         (f_rdy),
    .f_inst        (f_inst),
    .f_pc          (f_pc),
    .f_seq         (f_seq),
    .x_rdy         (x_rdy),
    .x_val         (x_val),
    .x_pc          (x_pc),
    .x_seq         (x_seq),
    .x_op1         (x_op1),
    .x_op2         (x_op2),
    .x_waddr       (x_waddr),
    .x_uop         (x_uop),
    .dec_uop       (dec_uop),
    .dec_imm       (dec_imm),
    .dec_pc_as_op1 (dec_pc_as_op1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .busy          (busy),
    .d_inst        (d_inst),
    .d_pc          (d_pc),
    .set_val       (set_val),
    .set_addr      (set_addr),
    .set_seq       (set_seq)
  );

endmodule

// File: include/issue_vectors.svh
/*
 * Stimulus and expected values for the decode-issue testbench,
 * one row per instruction
 */

`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

localparam int num_vecs = 9;

// Kinds of stall a row expects
localparam logic [1:0] stall_none   = 2'd0;
localparam logic [1:0] stall_hazard = 2'd1;
localparam logic [1:0] stall_pipe   = 2'd2;

// Row layout, in pattern order:
//   completion first:  pre_en pre_seq pre_waddr pre_wdata pre_wen
//   fetch:             inst pc seq rdy
//   expected issue:    exp_pipe exp_uop exp_op1 exp_op2 exp_waddr
//   stall:             stall hold rel_seq rel_waddr rel_wdata
typedef struct packed {
  logic        pre_en;
  logic [4:0]  pre_seq;
  logic [4:0]  pre_waddr;
  logic [31:0] pre_wdata;
  logic        pre_wen;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [4:0]  seq;
  logic [2:0]  rdy;
  logic [1:0]  exp_pipe;
  logic [2:0]  exp_uop;
  logic [31:0] exp_op1;
  logic [31:0] exp_op2;
  logic [4:0]  exp_waddr;
  logic [1:0]  stall;
  logic [3:0]  hold;
  logic [4:0]  rel_seq;
  logic [4:0]  rel_waddr;
  logic [31:0] rel_wdata;
} vec_t;

function automatic vec_t vector_row(input int idx);
  vec_t v;
  v = '0;
  case (idx)
    // ADDI x3, x1, -4
    0: v = '{1'b1, 5'd0, 5'd1, 32'h11, 1'b1, 32'hffc08193, 32'h100, 5'd1, 3'b111,
             2'd0, 3'd1, 32'h11, 32'hfffffffc, 5'd3, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // MUL x4, x3, x1 after x3 completes
    1: v = '{1'b1, 5'd1, 5'd3, 32'h33, 1'b1, 32'h02118233, 32'h104, 5'd2, 3'b111,
             2'd2, 3'd2, 32'h33, 32'h11, 5'd4, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // LW x5, 8(x4), pipe 0 cannot load
    2: v = '{1'b1, 5'd2, 5'd4, 32'h44, 1'b1, 32'h00822283, 32'h108, 5'd3, 3'b011,
             2'd1, 3'd3, 32'h44, 32'h8, 5'd5, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // ADD x6, x5, x1 waits on the load into x5
    3: v = '{1'b0, 5'd0, 5'd0, 32'h0, 1'b0, 32'h00128333, 32'h10c, 5'd4, 3'b111,
             2'd0, 3'd0, 32'h55, 32'h11, 5'd6, stall_hazard, 4'd3, 5'd3, 5'd5, 32'h55};
    // JAL x7, 8 held by back-pressure
    4: v = '{1'b1, 5'd4, 5'd6, 32'h66, 1'b1, 32'h008003ef, 32'h110, 5'd5, 3'b010,
             2'd1, 3'd4, 32'h110, 32'h8, 5'd7, stall_pipe, 4'd2, 5'd0, 5'd0, 32'h0};
    // JALR x0, -16(x6)
    5: v = '{1'b1, 5'd5, 5'd7, 32'h77, 1'b1, 32'hff030067, 32'h114, 5'd6, 3'b111,
             2'd0, 3'd5, 32'h66, 32'hfffffff0, 5'd0, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // ADD x0, x0, x7 after an attempted write of x0
    6: v = '{1'b1, 5'd7, 5'd0, 32'hdead, 1'b1, 32'h00700033, 32'h118, 5'd8, 3'b110,
             2'd1, 3'd0, 32'h0, 32'h77, 5'd0, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // ADDI x8, x0, 0x123
    7: v = '{1'b0, 5'd0, 5'd0, 32'h0, 1'b0, 32'h12300413, 32'h11c, 5'd9, 3'b111,
             2'd0, 3'd1, 32'h0, 32'h123, 5'd8, stall_none, 4'd0, 5'd0, 5'd0, 32'h0};
    // ADDI x8, x0, 1 is a WAW on x8
    8: v = '{1'b0, 5'd0, 5'd0, 32'h0, 1'b0, 32'h00100413, 32'h120, 5'd10, 3'b011,
             2'd0, 3'd1, 32'h0, 32'h1, 5'd8, stall_hazard, 4'd2, 5'd9, 5'd8, 32'h88};
    default: v = '0;
  endcase
  return v;
endfunction

`endif

// File: testbench/decode_issue_tb.sv
/*
 * Table-driven testbench for the decode-issue stage
 */

module decode_issue_tb;

  timeunit 1ns;
  timeprecision 1ps;

  `include "issue_vectors.svh"

  localparam int timeout_cycles = 20;

  // Pipe 0 ALU, pipe 1 ALU plus loads, pipe 2 multiply only
  localparam issue_pkg::op_mask_t [2:0] tb_pipe_ops = {
    issue_pkg::op_mask_t'(1) << issue_pkg::uop_mul,
    issue_pkg::op_mask_alu | (issue_pkg::op_mask_t'(1) << issue_pkg::uop_lw),
    issue_pkg::op_mask_alu
  };

  logic        clk;
  logic        rst;
  logic        f_val;
  logic        f_rdy;
  logic [31:0] f_inst;
  logic [31:0] f_pc;
  logic [4:0]  f_seq;
  logic [2:0]  x_val;
  logic [2:0]  x_rdy;
  logic [31:0] x_pc;
  logic [4:0]  x_seq;
  logic [31:0] x_op1;
  logic [31:0] x_op2;
  logic [4:0]  x_waddr;
  logic [2:0]  x_uop;
  logic        c_val;
  logic [4:0]  c_seq;
  logic [4:0]  c_waddr;
  logic [31:0] c_wdata;
  logic        c_wen;

  int errors;
  int bad_rows;
  bit row_bad;
  bit timed_out;

  decode_issue_top #(
    .seq_bits  (5),
    .num_pipes (3),
    .pipe_ops  (tb_pipe_ops)
  ) u_decode_issue_top (
    .clk     (clk),
    .rst     (rst),
    .f_val   (f_val),
    .f_rdy   (f_rdy),
    .f_inst  (f_inst),
    .f_pc    (f_pc),
    .f_seq   (f_seq),
    .x_val   (x_val),
    .x_rdy   (x_rdy),
    .x_pc    (x_pc),
    .x_seq   (x_seq),
    .x_op1   (x_op1),
    .x_op2   (x_op2),
    .x_waddr (x_waddr),
    .x_uop   (x_uop),
    .c_val   (c_val),
    .c_seq   (c_seq),
    .c_waddr (c_waddr),
    .c_wdata (c_wdata),
    .c_wen   (c_wen)
  );

  always #20 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
      row_bad = 1'b1;
    end
  endtask

  task automatic drive_completion(input logic [4:0] seq, input logic [4:0] waddr,
                                  input logic [31:0] wdata, input logic wen);
    c_val   = 1'b1;
    c_seq   = seq;
    c_waddr = waddr;
    c_wdata = wdata;
    c_wen   = wen;
  endtask

  initial begin
    vec_t v;
    int   n;
    bit   on_time;
    clk     = 1'b0;
    rst     = 1'b1;
    f_val   = 1'b0;
    f_inst  = '0;
    f_pc    = '0;
    f_seq   = '0;
    x_rdy   = '0;
    c_val   = 1'b0;
    c_seq   = '0;
    c_waddr = '0;
    c_wdata = '0;
    c_wen   = 1'b0;
    errors    = 0;
    bad_rows  = 0;
    timed_out = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < num_vecs && !timed_out; i++) begin
      v = vector_row(i);
      row_bad = 1'b0;
      // Completion published ahead of the instruction
      if (v.pre_en) begin
        @(negedge clk);
        drive_completion(v.pre_seq, v.pre_waddr, v.pre_wdata, v.pre_wen);
        @(negedge clk);
        c_val = 1'b0;
      end

      // ------------------------------------------------------
      // Fetch handshake
      // ------------------------------------------------------
      n = 0;
      @(negedge clk);
      while (!f_rdy && n < timeout_cycles) begin
        @(negedge clk);
        n++;
      end
      if (!f_rdy) begin
        $display("Row %0d: timed out waiting for f_rdy", i);
        timed_out = 1'b1;
        break;
      end
      f_val  = 1'b1;
      f_inst = v.inst;
      f_pc   = v.pc;
      f_seq  = v.seq;
      x_rdy  = (v.stall == stall_pipe) ? 3'b000 : v.rdy;

      @(negedge clk);
      f_val = 1'b0;
      // Stale completion with the wrong seq must not release
      if (v.stall == stall_hazard) begin
        drive_completion(v.rel_seq + 5'd1, v.rel_waddr, 32'hbad0bad0, 1'b0);
      end
      #5;
      if (v.stall != stall_none) begin
        for (int k = 0; k < v.hold; k++) begin
          if (k > 0) begin
            @(negedge clk);
            c_val = 1'b0;
            #5;
          end
          check_val("x_val during stall", 32'(3'b000), 32'(x_val));
          check_val("f_rdy during stall", 32'(1'b0), 32'(f_rdy));
        end
        @(negedge clk);
        if (v.stall == stall_hazard) begin
          drive_completion(v.rel_seq, v.rel_waddr, v.rel_wdata, 1'b1);
        end else begin
          x_rdy = v.rdy;
        end
        #5;
      end

      // ------------------------------------------------------
      // Issue
      // ------------------------------------------------------
      on_time = (x_val != '0);
      n = 0;
      while (x_val == '0 && n < timeout_cycles) begin
        @(negedge clk);
        #5;
        n++;
      end
      if (x_val == '0) begin
        $display("Row %0d: timed out waiting for x_val", i);
        timed_out = 1'b1;
        break;
      end
      if (!on_time) begin
        $display("Row %0d: x_val rose later than expected", i);
        errors++;
        row_bad = 1'b1;
      end
      check_val("x_val", 32'(3'b001 << v.exp_pipe), 32'(x_val));
      check_val("x_uop", 32'(v.exp_uop), 32'(x_uop));
      check_val("x_op1", v.exp_op1, x_op1);
      check_val("x_op2", v.exp_op2, x_op2);
      check_val("x_waddr", 32'(v.exp_waddr), 32'(x_waddr));
      check_val("x_pc", v.pc, x_pc);
      check_val("x_seq", 32'(v.seq), 32'(x_seq));
      @(negedge clk);
      c_val = 1'b0;

      if (row_bad) begin
        bad_rows++;
      end
      $display("Row %0d pc %h: %s", i, v.pc, row_bad ? "failed" : "ok");
    end

    $display("Rows %0d, failed rows %0d, failed checks %0d", num_vecs, bad_rows, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
hdl/issue_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/reg_scoreboard.sv
hdl/issue_ctrl.sv
hdl/decode_issue_top.sv
testbench/decode_issue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode-issue testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module decode_issue_tb -f flist.f \
  -o decode_issue_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/decode_issue_sim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && exit 0 || { echo "No result in sim.log"; exit 1; }
